// ==== Bender.yml ====
package:
  name: l2c

sources:
  - include_dirs:
      - logic
    files:
      - logic/l2c_pkg.sv
      - logic/l2c_ctrl.sv
      - logic/l2c_tag_array.sv
      - logic/l2c_data_array.sv
      - logic/l2c_refill.sv
      - logic/l2c_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/l2c_mem_model.sv
      - dv/tb_l2c.sv

// ==== dv/l2c_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2c_defines.svh"

// Behavioral main memory, one burst and one write in flight at a time
module l2c_mem_model (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              ar_valid,
	output logic              ar_ready,
	input  l2c_pkg::addr_t    ar_addr,
	output logic              r_valid,
	input  logic              r_ready,
	output l2c_pkg::mem_rd_t  r_beat,
	input  logic              w_valid,
	output logic              w_ready,
	input  l2c_pkg::mem_wr_t  w,
	output logic              b_valid,
	input  logic              b_ready,
	output int                ar_count
);

	localparam int BYTE_W = `L2C_OFFS_W - `L2C_WORD_W;
	localparam int WORD_AW = `L2C_ADDR_W - BYTE_W;

	typedef logic [WORD_AW-1:0] word_addr_t;

	// Sparse storage, an untouched word reads back its own word address
	l2c_pkg::data_t mem [word_addr_t];

	logic ar_fire;
	logic r_fire;
	logic w_fire;
	logic b_fire;
	logic burst_on;
	logic b_pend;
	word_addr_t burst_base;
	word_addr_t wa;
	int beat;

	function automatic l2c_pkg::data_t read_word(word_addr_t addr);
		if (mem.exists(addr)) begin
			return mem[addr];
		end
		return l2c_pkg::data_t'(addr);
	endfunction

	initial begin
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_beat = '0;
		w_ready = 1'b0;
		b_valid = 1'b0;
		ar_count = 0;
		burst_on = 1'b0;
		b_pend = 1'b0;
		burst_base = '0;
		beat = 0;
		forever begin
			// Handshakes seen with the values that held before the edge
			@(posedge clk);
			ar_fire = ar_valid && ar_ready;
			r_fire = r_valid && r_ready;
			w_fire = w_valid && w_ready;
			b_fire = b_valid && b_ready;
			if (ar_fire) begin
				ar_count++;
				burst_on = 1'b1;
				burst_base = word_addr_t'(ar_addr >> BYTE_W);
				beat = 0;
			end
			// Strobed byte merge
			if (w_fire) begin
				wa = word_addr_t'(w.addr >> BYTE_W);
				mem[wa] = read_word(wa);
				for (int i = 0; i < `L2C_STRB_W; i++) begin
					if (w.strb[i]) begin
						mem[wa][i*8 +: 8] = w.data[i*8 +: 8];
					end
				end
			end
			@(negedge clk);
			if (!rst_n) begin
				ar_ready = 1'b0;
				r_valid = 1'b0;
				w_ready = 1'b0;
				b_valid = 1'b0;
				burst_on = 1'b0;
				b_pend = 1'b0;
			end else begin
				if (r_fire) begin
					r_valid = 1'b0;
					beat++;
					if (beat == `L2C_LINE_BEATS) begin
						burst_on = 1'b0;
					end
				end
				if (b_fire) begin
					b_valid = 1'b0;
					b_pend = 1'b0;
				end
				if (w_fire) begin
					b_pend = 1'b1;
				end
				// Random stalls on every channel, valids hold until taken
				ar_ready = ($urandom % 2) == 0;
				w_ready = ($urandom % 2) == 0;
				if (burst_on && !r_valid && ($urandom % 2) == 0) begin
					r_valid = 1'b1;
					r_beat.data = read_word(burst_base + word_addr_t'(beat));
					r_beat.last = (beat == `L2C_LINE_BEATS - 1);
				end
				if (b_pend && !b_valid && ($urandom % 2) == 0) begin
					b_valid = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_l2c.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2c_defines.svh"

module tb_l2c;

	localparam int BYTE_W = `L2C_OFFS_W - `L2C_WORD_W;
	localparam int ACCEPT_LIMIT = 100;
	localparam int RSP_LIMIT = 1000;

	logic clk;
	logic rst_n;
	logic req_valid;
	logic req_ready;
	l2c_pkg::cpu_req_t req;
	logic rsp_valid;
	logic rsp_ready;
	l2c_pkg::data_t rsp_data;
	logic ar_valid;
	logic ar_ready;
	l2c_pkg::addr_t ar_addr;
	logic r_valid;
	logic r_ready;
	l2c_pkg::mem_rd_t r_beat;
	logic w_valid;
	logic w_ready;
	l2c_pkg::mem_wr_t w;
	logic b_valid;
	logic b_ready;
	logic fence_req;
	logic fence_done;
	int ar_count;

	// Mirror of memory keyed by word address
	l2c_pkg::data_t mirror [l2c_pkg::addr_t];
	l2c_pkg::data_t exp_q [$];
	int errors;
	int checks;
	int rsp_count;
	int exp_ar;
	logic rsp_bp;

	l2c_top dut (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_ready(req_ready), .req(req),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
		.r_valid(r_valid), .r_ready(r_ready), .r_beat(r_beat),
		.w_valid(w_valid), .w_ready(w_ready), .w(w),
		.b_valid(b_valid), .b_ready(b_ready),
		.fence_req(fence_req), .fence_done(fence_done)
	);

	l2c_mem_model u_mem (
		.clk(clk), .rst_n(rst_n),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
		.r_valid(r_valid), .r_ready(r_ready), .r_beat(r_beat),
		.w_valid(w_valid), .w_ready(w_ready), .w(w),
		.b_valid(b_valid), .b_ready(b_ready), .ar_count(ar_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Expected word, untouched memory holds its own word address
	function automatic l2c_pkg::data_t ref_word(l2c_pkg::addr_t addr);
		l2c_pkg::addr_t wa;
		wa = addr >> BYTE_W;
		if (mirror.exists(wa)) begin
			return mirror[wa];
		end
		return l2c_pkg::data_t'(wa);
	endfunction

	function automatic l2c_pkg::data_t merge_bytes(l2c_pkg::data_t old_w, l2c_pkg::data_t new_w,
			l2c_pkg::strb_t strb);
		l2c_pkg::data_t res;
		res = old_w;
		for (int i = 0; i < `L2C_STRB_W; i++) begin
			if (strb[i]) begin
				res[i*8 +: 8] = new_w[i*8 +: 8];
			end
		end
		return res;
	endfunction

	task automatic stop_on_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("STATUS: FAIL");
		$finish;
	endtask

	task automatic check_ar(input int expected);
		checks++;
		if (ar_count != expected) begin
			$display("Mismatch at %0t: ar_count got %0d expected %0d", $time, ar_count, expected);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input string name);
		$display("Test %0d %s finished, errors so far %0d", num, name, errors);
	endtask

	// One request, then wait for its response
	task automatic issue_req(input logic wr, input l2c_pkg::addr_t addr,
			input l2c_pkg::data_t data, input l2c_pkg::strb_t strb);
		int n;
		int target;
		logic taken;
		target = rsp_count + 1;
		@(negedge clk);
		req_valid = 1'b1;
		req.wr = wr;
		req.addr = addr;
		req.data = data;
		req.strb = strb;
		// Write-through updates the mirror as soon as it is issued
		if (wr) begin
			mirror[addr >> BYTE_W] = merge_bytes(ref_word(addr), data, strb);
			exp_q.push_back('0);
		end else begin
			exp_q.push_back(ref_word(addr));
		end
		taken = 1'b0;
		n = 0;
		while (!taken) begin
			@(posedge clk);
			taken = req_ready;
			n++;
			if (!taken && n > ACCEPT_LIMIT) begin
				stop_on_timeout("request was never accepted");
			end
		end
		@(negedge clk);
		req_valid = 1'b0;
		n = 0;
		while (rsp_count < target) begin
			@(negedge clk);
			n++;
			if (n > RSP_LIMIT) begin
				stop_on_timeout("no response arrived for the request");
			end
		end
	endtask

	// Random back-pressure only while enabled
	always @(negedge clk) begin
		if (rsp_bp) begin
			rsp_ready = ($urandom % 2) == 0;
		end else begin
			rsp_ready = 1'b1;
		end
	end

	// Compare every response transfer against the queued expectation
	always @(posedge clk) begin : compare
		l2c_pkg::data_t exp_d;
		if (rst_n && rsp_valid && rsp_ready) begin
			if (exp_q.size() == 0) begin
				$display("Error at %0t: response arrived with no request outstanding", $time);
				errors++;
			end else begin
				exp_d = exp_q.pop_front();
				checks++;
				if (rsp_data !== exp_d) begin
					$display("Mismatch at %0t: rsp_data got %h expected %h", $time, rsp_data, exp_d);
					errors++;
				end
			end
			rsp_count++;
		end
	end

	initial begin
		int n;
		int pulses;
		logic wr;
		l2c_pkg::addr_t a;
		void'($urandom(32'h4fd0680e));
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b1;
		fence_req = 1'b0;
		rsp_bp = 1'b0;
		errors = 0;
		checks = 0;
		rsp_count = 0;
		exp_ar = 0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// No request is taken before the first edge out of reset
		checks++;
		if (req_ready !== 1'b0) begin
			$display("Mismatch at %0t: req_ready got %b expected 0", $time, req_ready);
			errors++;
		end

		// Quiet outputs before any traffic
		repeat (8) begin
			@(negedge clk);
			checks++;
			if (rsp_valid || ar_valid || r_ready || w_valid || b_ready || fence_done) begin
				$display("Error at %0t: an output went active before the first request", $time);
				errors++;
			end
			if (req_ready !== 1'b1) begin
				$display("Mismatch at %0t: req_ready got %b expected 1", $time, req_ready);
				errors++;
			end
		end
		report_test(1, "reset state");

		// Two lines of set 0, one AR each
		issue_req(1'b0, 32'h0000_1008, '0, '0);
		exp_ar++;
		check_ar(exp_ar);
		issue_req(1'b0, 32'h0000_2010, '0, '0);
		exp_ar++;
		check_ar(exp_ar);
		report_test(2, "read misses");

		for (int i = 0; i < `L2C_LINE_BEATS; i++) begin
			issue_req(1'b0, 32'h0000_1000 + i * 8, '0, '0);
			issue_req(1'b0, 32'h0000_2000 + i * 8, '0, '0);
		end
		check_ar(exp_ar);
		report_test(3, "read hits");

		// Cached word then uncached word, no allocation on the write miss
		issue_req(1'b1, 32'h0000_1018, 64'h1122_3344_5566_7788, 8'h0F);
		issue_req(1'b1, 32'h0000_3008, 64'h99AA_BBCC_DDEE_FF00, 8'hF0);
		check_ar(exp_ar);
		issue_req(1'b0, 32'h0000_1018, '0, '0);
		check_ar(exp_ar);
		issue_req(1'b0, 32'h0000_3008, '0, '0);
		exp_ar++;
		check_ar(exp_ar);
		report_test(4, "write-through");

		@(negedge clk);
		fence_req = 1'b1;
		n = 0;
		pulses = 0;
		while (pulses == 0) begin
			@(negedge clk);
			n++;
			if (fence_done) begin
				pulses++;
			end
			if (pulses == 0 && n > 20) begin
				stop_on_timeout("fence_done never pulsed");
			end
		end
		fence_req = 1'b0;
		checks++;
		if (n != 1) begin
			$display("Error at %0t: fence_done came %0d cycles after fence_req", $time, n);
			errors++;
		end
		repeat (5) begin
			@(negedge clk);
			if (fence_done) begin
				pulses++;
			end
		end
		checks++;
		if (pulses != 1) begin
			$display("Error at %0t: fence_done pulsed %0d times", $time, pulses);
			errors++;
		end
		// Line filled last was surely resident before the flush
		issue_req(1'b0, 32'h0000_3008, '0, '0);
		exp_ar++;
		check_ar(exp_ar);
		issue_req(1'b0, 32'h0000_1018, '0, '0);
		exp_ar++;
		check_ar(exp_ar);
		report_test(5, "fence");

		// 32 lines over 8 sets keeps both hits and evictions frequent
		rsp_bp = 1'b1;
		repeat (200) begin
			wr = ($urandom % 3) == 0;
			a = 32'h0000_4000 + (($urandom % 128) << BYTE_W);
			issue_req(wr, a, {$urandom, $urandom}, l2c_pkg::strb_t'($urandom));
		end
		rsp_bp = 1'b0;
		report_test(6, "random traffic");

		$display("Tests run 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/l2c_pkg.sv
logic/l2c_ctrl.sv
logic/l2c_tag_array.sv
logic/l2c_data_array.sv
logic/l2c_refill.sv
logic/l2c_top.sv
dv/l2c_mem_model.sv
dv/tb_l2c.sv

// ==== logic/l2c_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2c_defines.svh"

// One transaction in flight; reads allocate, writes go through
module l2c_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req_valid,
	output logic               req_ready,
	input  l2c_pkg::cpu_req_t  req,
	output logic               rsp_valid,
	input  logic               rsp_ready,
	output l2c_pkg::data_t     rsp_data,
	output logic               w_valid,
	input  logic               w_ready,
	output l2c_pkg::mem_wr_t   w,
	input  logic               b_valid,
	output logic               b_ready,
	input  logic               fence_req,
	output logic               fence_done,
	// Array and refill side
	input  logic               hit,
	input  l2c_pkg::data_t     hit_data,
	output l2c_pkg::addr_t     cur_addr,
	output logic               fill_start,
	input  logic               fill_done,
	input  logic               beat_valid,
	input  l2c_pkg::data_t     beat_data,
	output logic               wr_en,
	output l2c_pkg::data_t     wr_data,
	output l2c_pkg::strb_t     wr_strb,
	output logic               flush
);

	l2c_pkg::l2c_state_e state_q;
	l2c_pkg::l2c_state_e state_d;
	l2c_pkg::cpu_req_t req_q;
	l2c_pkg::word_idx_t fill_word_q;
	logic live_q;
	logic w_sent_q;
	logic req_take;
	logic fence_take;

	// Nothing is taken in the first cycle out of reset
	// Fence wins over a request presented in the same cycle
	assign req_ready = live_q && (state_q == l2c_pkg::IDLE) && !fence_req;
	assign req_take = req_valid && req_ready;
	assign fence_take = live_q && (state_q == l2c_pkg::IDLE) && fence_req;

	// Valid bits drop on the edge that enters FENCE
	assign flush = fence_take;
	assign fence_done = (state_q == l2c_pkg::FENCE);

	// Read miss starts the line fetch, write misses never allocate
	assign fill_start = (state_q == l2c_pkg::LOOKUP) && !req_q.wr && !hit;

	// Word bits walk the line while beats arrive
	assign cur_addr = (state_q == l2c_pkg::REFILL) ?
		{req_q.addr[`L2C_ADDR_W-1:`L2C_OFFS_W], fill_word_q,
		 {(`L2C_OFFS_W-`L2C_WORD_W){1'b0}}} : req_q.addr;

	// Array update: whole beats on refill, client strobes on a write hit
	assign wr_en = ((state_q == l2c_pkg::LOOKUP) && req_q.wr && hit) ||
		((state_q == l2c_pkg::REFILL) && beat_valid);
	assign wr_data = (state_q == l2c_pkg::REFILL) ? beat_data : req_q.data;
	assign wr_strb = (state_q == l2c_pkg::REFILL) ? '1 : req_q.strb;

	// Response, the arrays hold still while it waits
	assign rsp_valid = (state_q == l2c_pkg::READ_RSP) || (state_q == l2c_pkg::WRITE_RSP);
	assign rsp_data = (state_q == l2c_pkg::READ_RSP) ? hit_data : '0;

	// Write-through, W first then wait on B
	assign w_valid = (state_q == l2c_pkg::WRITE_MEM) && !w_sent_q;
	assign b_ready = (state_q == l2c_pkg::WRITE_MEM) && w_sent_q;
	assign w = {req_q.addr, req_q.data, req_q.strb};

	always_comb begin
		state_d = state_q;
		case (state_q)
			l2c_pkg::IDLE: begin
				if (fence_take) begin
					state_d = l2c_pkg::FENCE;
				end else if (req_take) begin
					state_d = l2c_pkg::LOOKUP;
				end
			end
			l2c_pkg::LOOKUP: begin
				if (req_q.wr) begin
					state_d = l2c_pkg::WRITE_MEM;
				end else if (hit) begin
					state_d = l2c_pkg::READ_RSP;
				end else begin
					state_d = l2c_pkg::REFILL;
				end
			end
			// Second lookup after the fill turns into a hit
			l2c_pkg::REFILL: begin
				if (fill_done) begin
					state_d = l2c_pkg::LOOKUP;
				end
			end
			l2c_pkg::WRITE_MEM: begin
				if (b_valid && b_ready) begin
					state_d = l2c_pkg::WRITE_RSP;
				end
			end
			l2c_pkg::READ_RSP, l2c_pkg::WRITE_RSP: begin
				if (rsp_ready) begin
					state_d = l2c_pkg::IDLE;
				end
			end
			default: state_d = l2c_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= l2c_pkg::IDLE;
			live_q <= 1'b0;
			w_sent_q <= 1'b0;
			fill_word_q <= '0;
		end else begin
			state_q <= state_d;
			live_q <= 1'b1;
			if (w_valid && w_ready) begin
				w_sent_q <= 1'b1;
			end else if (b_valid && b_ready) begin
				w_sent_q <= 1'b0;
			end
			// Burst starts at word 0 of the line
			if (fill_start) begin
				fill_word_q <= '0;
			end else if (beat_valid) begin
				fill_word_q <= fill_word_q + 1'b1;
			end
		end
	end

	// Request payload
	always_ff @(posedge clk) begin
		if (req_take) begin
			req_q <= req;
		end
	end

	// Response word holds still under back-pressure
	a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

	a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
		w_valid && !w_ready |=> w_valid && $stable(w));

endmodule

`default_nettype wire

// ==== logic/l2c_data_array.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2c_defines.svh"

module l2c_data_array (
	input  logic                 clk,
	input  l2c_pkg::set_t        set_idx,
	input  l2c_pkg::word_idx_t   word_idx,
	input  l2c_pkg::way_oh_t     way_sel,
	input  logic                 wr_en,
	input  l2c_pkg::data_t       wr_data,
	input  l2c_pkg::strb_t       wr_strb,
	output l2c_pkg::data_t       rd_data
);

	l2c_pkg::data_t line_mem [`L2C_SETS][`L2C_WAYS][`L2C_LINE_BEATS];

	// Byte lanes written under the strobes
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int w = 0; w < `L2C_WAYS; w++) begin
				for (int b = 0; b < `L2C_STRB_W; b++) begin
					if (way_sel[w] && wr_strb[b]) begin
						line_mem[set_idx][w][word_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
					end
				end
			end
		end
	end

	// AND-OR select across ways, zero when no way is picked
	always_comb begin
		rd_data = '0;
		for (int w = 0; w < `L2C_WAYS; w++) begin
			if (way_sel[w]) begin
				rd_data = rd_data | line_mem[set_idx][w][word_idx];
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/l2c_defines.svh ====
`ifndef L2C_DEFINES_SVH
`define L2C_DEFINES_SVH

// Bus widths
`define L2C_ADDR_W 32
`define L2C_DATA_W 64
`define L2C_STRB_W 8

// Cache geometry, 8 sets of 2 ways with 4 words per line
`define L2C_LINE_BEATS 4
`define L2C_SETS 8
`define L2C_WAYS 2

// Address split: tag | set | word | byte
`define L2C_OFFS_W 5
`define L2C_WORD_W 2
`define L2C_SET_W 3
`define L2C_TAG_W 24

// Any nonzero value keeps the LFSR out of the lock-up state
`define L2C_LFSR_SEED 16'hACE1

`endif

// ==== logic/l2c_pkg.sv ====
`default_nettype none

`include "l2c_defines.svh"

package l2c_pkg;

	// Plain vectors with a meaning
	typedef logic [`L2C_ADDR_W-1:0] addr_t;
	typedef logic [`L2C_DATA_W-1:0] data_t;
	typedef logic [`L2C_STRB_W-1:0] strb_t;
	typedef logic [`L2C_TAG_W-1:0] tag_t;
	typedef logic [`L2C_SET_W-1:0] set_t;
	typedef logic [`L2C_WORD_W-1:0] word_idx_t;
	typedef logic [`L2C_WAYS-1:0] way_oh_t;

	// Client request, one word read or strobed write
	typedef struct packed {
		logic wr;
		addr_t addr;
		data_t data;
		strb_t strb;
	} cpu_req_t;

	// Write-through beat towards memory
	typedef struct packed {
		addr_t addr;
		data_t data;
		strb_t strb;
	} mem_wr_t;

	// One beat of a refill burst
	typedef struct packed {
		data_t data;
		logic last;
	} mem_rd_t;

	typedef enum logic [2:0] {
		IDLE, LOOKUP, REFILL, READ_RSP, WRITE_MEM, WRITE_RSP, FENCE
	} l2c_state_e;

endpackage

`default_nettype wire

// ==== logic/l2c_refill.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2c_defines.svh"

// Fixed incrementing burst of one line
module l2c_refill (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               fill_start,
	input  l2c_pkg::addr_t     line_addr,
	output logic               ar_valid,
	input  logic               ar_ready,
	output l2c_pkg::addr_t     ar_addr,
	input  logic               r_valid,
	output logic               r_ready,
	input  l2c_pkg::mem_rd_t   r_beat,
	output logic               beat_valid,
	output logic               fill_done
);

	logic ar_valid_q;
	logic r_ready_q;
	l2c_pkg::word_idx_t beat_cnt;
	l2c_pkg::addr_t ar_addr_q;

	assign ar_valid = ar_valid_q;
	assign ar_addr = ar_addr_q;
	assign r_ready = r_ready_q;
	assign beat_valid = r_valid && r_ready_q;
	assign fill_done = beat_valid && r_beat.last;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ar_valid_q <= 1'b0;
			r_ready_q <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (fill_start) begin
				ar_valid_q <= 1'b1;
			end else if (ar_valid_q && ar_ready) begin
				ar_valid_q <= 1'b0;
			end
			// Open for data from the AR transfer up to the last beat
			if (ar_valid_q && ar_ready) begin
				r_ready_q <= 1'b1;
			end else if (fill_done) begin
				r_ready_q <= 1'b0;
			end
			if (fill_start) begin
				beat_cnt <= '0;
			end else if (beat_valid) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// Line aligned, stays put until the AR transfer
	always_ff @(posedge clk) begin
		if (fill_start) begin
			ar_addr_q <= {line_addr[`L2C_ADDR_W-1:`L2C_OFFS_W], {`L2C_OFFS_W{1'b0}}};
		end
	end

	a_last_on_final_beat: assert property (@(posedge clk) disable iff (!rst_n)
		beat_valid |-> (r_beat.last == (beat_cnt == l2c_pkg::word_idx_t'(`L2C_LINE_BEATS-1))));

endmodule

`default_nettype wire

// ==== logic/l2c_tag_array.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2c_defines.svh"

module l2c_tag_array (
	input  logic               clk,
	input  logic               rst_n,
	input  l2c_pkg::addr_t     cur_addr,
	input  logic               fill_start,
	input  logic               flush,
	output logic               hit,
	output l2c_pkg::way_oh_t   hit_way,
	output l2c_pkg::way_oh_t   fill_way
);

	l2c_pkg::tag_t tag_mem [`L2C_SETS][`L2C_WAYS];
	logic [`L2C_SETS-1:0][`L2C_WAYS-1:0] valid_q;
	logic [15:0] lfsr_q;
	l2c_pkg::set_t set_idx;
	l2c_pkg::tag_t cur_tag;
	l2c_pkg::way_oh_t set_valid;
	l2c_pkg::way_oh_t victim;
	l2c_pkg::way_oh_t fill_way_q;

	assign set_idx = cur_addr[`L2C_OFFS_W +: `L2C_SET_W];
	assign cur_tag = cur_addr[`L2C_ADDR_W-1 -: `L2C_TAG_W];
	assign set_valid = valid_q[set_idx];

	// All ways of the set compared in parallel
	always_comb begin
		for (int w = 0; w < `L2C_WAYS; w++) begin
			hit_way[w] = set_valid[w] && (tag_mem[set_idx][w] == cur_tag);
		end
	end

	assign hit = |hit_way;

	// Lowest free way first, LFSR pick once the set is full
	always_comb begin
		victim = '0;
		if (&set_valid) begin
			victim[lfsr_q[$clog2(`L2C_WAYS)-1:0]] = 1'b1;
		end else begin
			// Walk downwards so the lowest free way is the last one kept
			for (int w = `L2C_WAYS-1; w >= 0; w--) begin
				if (!set_valid[w]) begin
					victim = l2c_pkg::way_oh_t'(1) << w;
				end
			end
		end
	end

	// Free running, taps 16 14 13 11
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr_q <= `L2C_LFSR_SEED;
		end else begin
			lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
		end
	end

	// Line becomes valid as soon as the fill is launched
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			fill_way_q <= '0;
		end else if (flush) begin
			valid_q <= '0;
		end else if (fill_start) begin
			valid_q[set_idx] <= set_valid | victim;
			// Held so refill beats keep landing in the same way
			fill_way_q <= victim;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_start) begin
			for (int w = 0; w < `L2C_WAYS; w++) begin
				if (victim[w]) begin
					tag_mem[set_idx][w] <= cur_tag;
				end
			end
		end
	end

	assign fill_way = fill_way_q;

	// Same tag never lives in two ways of one set
	a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(hit_way));

endmodule

`default_nettype wire

// ==== logic/l2c_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2c_defines.svh"

module l2c_top (
	input  logic               clk,
	input  logic               rst_n,
	// Client port
	input  logic               req_valid,
	output logic               req_ready,
	input  l2c_pkg::cpu_req_t  req,
	output logic               rsp_valid,
	input  logic               rsp_ready,
	output l2c_pkg::data_t     rsp_data,
	// Memory read address and data
	output logic               ar_valid,
	input  logic               ar_ready,
	output l2c_pkg::addr_t     ar_addr,
	input  logic               r_valid,
	output logic               r_ready,
	input  l2c_pkg::mem_rd_t   r_beat,
	// Memory write and write response
	output logic               w_valid,
	input  logic               w_ready,
	output l2c_pkg::mem_wr_t   w,
	input  logic               b_valid,
	output logic               b_ready,
	// Fence
	input  logic               fence_req,
	output logic               fence_done
);

	l2c_pkg::addr_t cur_addr;
	l2c_pkg::data_t hit_data;
	l2c_pkg::data_t wr_data;
	l2c_pkg::strb_t wr_strb;
	l2c_pkg::way_oh_t hit_way;
	l2c_pkg::way_oh_t fill_way;
	l2c_pkg::way_oh_t way_sel;
	logic hit;
	logic fill_start;
	logic fill_done;
	logic beat_valid;
	logic wr_en;
	logic flush;

	// Refill beats go to the victim way, everything else to the hit way
	assign way_sel = r_ready ? fill_way : hit_way;

	l2c_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_ready(req_ready), .req(req),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
		.w_valid(w_valid), .w_ready(w_ready), .w(w),
		.b_valid(b_valid), .b_ready(b_ready),
		.fence_req(fence_req), .fence_done(fence_done),
		.hit(hit), .hit_data(hit_data), .cur_addr(cur_addr),
		.fill_start(fill_start), .fill_done(fill_done),
		.beat_valid(beat_valid), .beat_data(r_beat.data),
		.wr_en(wr_en), .wr_data(wr_data), .wr_strb(wr_strb), .flush(flush)
	);

	l2c_tag_array u_tag_array (
		.clk(clk), .rst_n(rst_n), .cur_addr(cur_addr),
		.fill_start(fill_start), .flush(flush),
		.hit(hit), .hit_way(hit_way), .fill_way(fill_way)
	);

	// Set and word index come straight from the controller address
	l2c_data_array u_data_array (
		.clk(clk),
		.set_idx(cur_addr[`L2C_OFFS_W +: `L2C_SET_W]),
		.word_idx(cur_addr[`L2C_OFFS_W-`L2C_WORD_W +: `L2C_WORD_W]),
		.way_sel(way_sel), .wr_en(wr_en), .wr_data(wr_data), .wr_strb(wr_strb),
		.rd_data(hit_data)
	);

	l2c_refill u_refill (
		.clk(clk), .rst_n(rst_n), .fill_start(fill_start), .line_addr(cur_addr),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
		.r_valid(r_valid), .r_ready(r_ready), .r_beat(r_beat),
		.beat_valid(beat_valid), .fill_done(fill_done)
	);

endmodule

`default_nettype wire
